/* sim.f */
verilog/hm_pkg.sv
verilog/hm_tag_store.sv
verilog/hm_miss_counters.sv
verilog/hm_lock_table.sv
verilog/hm_unit.sv
bench/hm_assert.sv
bench/hm_tb.sv

/* Makefile */
TOP := hm_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

# the log decides the result, the fail message or a missing pass line fails the target
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/hm_tb.sv */
`timescale 1ns/1ps

module hm_tb;

  localparam int unsigned NUM_DESC   = 300;
  localparam int unsigned POOL_SIZE  = 12;
  // 60 cycles per descriptor plus reset and the clear walk
  localparam int unsigned MAX_CYCLES = NUM_DESC * 60 + hm_pkg::SETS + 2;
  localparam int unsigned CNT_FULL   = (1 << hm_pkg::CNT_W) - 1;

  logic          clk_i;
  logic          reset_i;
  hm_pkg::desc_t desc_i;
  logic          valid_i;
  logic          ready_o;
  hm_pkg::desc_t desc_o;
  logic          hit_valid_o;
  logic          hit_ready_i;
  logic          miss_valid_o;
  logic          miss_ready_i;
  hm_pkg::lock_t w_unlock_i;
  logic          w_unlock_req_i;
  logic          w_unlock_gnt_o;
  hm_pkg::lock_t r_unlock_i;
  logic          r_unlock_req_i;
  logic          r_unlock_gnt_o;
  hm_pkg::cnt_t  cnt_down_i;

  //////////////////////////////////////////////////
  // reference model state
  //////////////////////////////////////////////////
  hm_pkg::tag_t tag_m   [hm_pkg::SETS][hm_pkg::WAYS];
  logic         valid_m [hm_pkg::SETS][hm_pkg::WAYS];
  logic         dirty_m [hm_pkg::SETS][hm_pkg::WAYS];
  logic         lock_m  [hm_pkg::SETS][hm_pkg::WAYS];
  // round-robin victim as a way number
  int unsigned  rr_m    [hm_pkg::SETS];
  int unsigned  count_m [hm_pkg::NUM_IDS];

  // line addresses with the offset bits zero
  logic [hm_pkg::ADDR_W-1:0] pool [POOL_SIZE];
  // accepted and not yet out
  hm_pkg::desc_t sent_q [$];
  // pending downstream unlocks and count-downs with their delays
  hm_pkg::lock_t w_line_q [$];
  int unsigned   w_delay_q [$];
  hm_pkg::lock_t r_line_q [$];
  int unsigned   r_delay_q [$];
  hm_pkg::id_t   cnt_id_q [$];
  int unsigned   cnt_delay_q [$];

  int unsigned   cycle_cnt;
  int unsigned   accept_cnt;
  int unsigned   done_cnt;
  logic          accepted_now;
  // output seen stalled on the last edge
  logic          held_valid;
  hm_pkg::desc_t held_desc;

  hm_unit u_hm_unit (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .desc_i         (desc_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .desc_o         (desc_o),
    .hit_valid_o    (hit_valid_o),
    .hit_ready_i    (hit_ready_i),
    .miss_valid_o   (miss_valid_o),
    .miss_ready_i   (miss_ready_i),
    .w_unlock_i     (w_unlock_i),
    .w_unlock_req_i (w_unlock_req_i),
    .w_unlock_gnt_o (w_unlock_gnt_o),
    .r_unlock_i     (r_unlock_i),
    .r_unlock_req_i (r_unlock_req_i),
    .r_unlock_gnt_o (r_unlock_gnt_o),
    .cnt_down_i     (cnt_down_i)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////
  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(string test, logic [63:0] expected, logic [63:0] actual);
    $display("Error %s: expected %0h, actual %0h", test, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  function automatic hm_pkg::desc_t random_desc();
    hm_pkg::desc_t                d;
    logic [hm_pkg::OFFSET_W-1:0]  offset;
    logic [hm_pkg::ADDR_W-1:0]    line;
    d      = '0;
    offset = $urandom;
    line   = pool[$urandom_range(POOL_SIZE - 1)];
    d.addr = {line[hm_pkg::ADDR_W-1:hm_pkg::OFFSET_W], offset};
    d.id   = $urandom_range(hm_pkg::NUM_IDS - 1);
    d.rw   = $urandom_range(1);
    return d;
  endfunction

  // model lookup of the oldest descriptor against what came out
  task automatic check_output();
    hm_pkg::desc_t  in_d;
    hm_pkg::desc_t  exp_d;
    hm_pkg::index_t idx;
    hm_pkg::tag_t   tag;
    hm_pkg::lock_t  line;
    int             way;
    logic           hit;
    logic           exp_miss;
    assert (sent_q.size() != 0)
      else report_problem("output transfer without an accepted descriptor");
    in_d = sent_q.pop_front();
    idx  = in_d.addr[hm_pkg::OFFSET_W +: hm_pkg::INDEX_W];
    tag  = in_d.addr[hm_pkg::ADDR_W-1 -: hm_pkg::TAG_W];
    hit  = 1'b0;
    way  = -1;
    for (int w = 0; w < hm_pkg::WAYS; w++) begin
      if (valid_m[idx][w] && (tag_m[idx][w] == tag)) begin
        hit = 1'b1;
        way = w;
      end
    end
    // a miss takes the lowest free way or the round-robin way
    if (!hit) begin
      for (int w = hm_pkg::WAYS - 1; w >= 0; w--) begin
        if (!valid_m[idx][w]) begin
          way = w;
        end
      end
      if (way < 0) begin
        way = rr_m[idx];
      end
    end
    exp_d           = in_d;
    exp_d.way_ind   = hm_pkg::way_ind_t'(1) << way;
    exp_d.refill    = !hit;
    exp_d.evict     = !hit && valid_m[idx][way] && dirty_m[idx][way];
    exp_d.evict_tag = exp_d.evict ? tag_m[idx][way] : '0;
    // hits follow outstanding misses of their id
    exp_miss        = !hit || (count_m[in_d.id] != 0);
    assert (desc_o == exp_d) else report_mismatch("lookup", exp_d, desc_o);
    assert (miss_valid_o == exp_miss) else report_mismatch("routing", exp_miss, miss_valid_o);
    assert (hit_valid_o == !exp_miss)
      else report_mismatch("hit routing", !exp_miss, hit_valid_o);
    assert (!lock_m[idx][way]) else report_problem("descriptor sent for a locked line");
    assert (count_m[in_d.id] < CNT_FULL)
      else report_problem("descriptor sent while its miss counter was full");
    // rr only moves when a valid line is replaced
    if (!hit && valid_m[idx][way]) begin
      rr_m[idx] = (rr_m[idx] + 1) % hm_pkg::WAYS;
    end
    dirty_m[idx][way] = hit ? (dirty_m[idx][way] | in_d.rw) : in_d.rw;
    valid_m[idx][way] = 1'b1;
    tag_m[idx][way]   = tag;
    lock_m[idx][way]  = 1'b1;
    line.index        = idx;
    line.way_ind      = exp_d.way_ind;
    if (in_d.rw) begin
      w_line_q.push_back(line);
      w_delay_q.push_back($urandom_range(8));
    end else begin
      r_line_q.push_back(line);
      r_delay_q.push_back($urandom_range(8));
    end
    if (exp_miss) begin
      count_m[in_d.id]++;
      cnt_id_q.push_back(in_d.id);
      cnt_delay_q.push_back($urandom_range(10));
    end
    done_cnt++;
  endtask

  // samples the values that were stable before the edge
  task automatic observe_cycle();
    logic fire;
    fire = (hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i);
    // write unlock beats read unlock
    assert (w_unlock_gnt_o == w_unlock_req_i)
      else report_mismatch("write grant", w_unlock_req_i, w_unlock_gnt_o);
    assert (r_unlock_gnt_o == (r_unlock_req_i && !w_unlock_req_i))
      else report_mismatch("read grant", r_unlock_req_i && !w_unlock_req_i, r_unlock_gnt_o);
    if (held_valid) begin
      assert (desc_o == held_desc) else report_mismatch("back-pressure", held_desc, desc_o);
      assert (hit_valid_o || miss_valid_o)
        else report_problem("output valid dropped before the transfer");
    end
    held_valid = 1'b0;
    if (fire) begin
      check_output();
    end else if (hit_valid_o || miss_valid_o) begin
      assert (!ready_o) else report_problem("input accepted while the output was stalled");
      held_valid = 1'b1;
      held_desc  = desc_o;
    end
    // granted unlocks clear their lines on this edge
    if (w_unlock_req_i) begin
      for (int w = 0; w < hm_pkg::WAYS; w++) begin
        if (w_unlock_i.way_ind[w]) begin
          lock_m[w_unlock_i.index][w] = 1'b0;
        end
      end
      void'(w_line_q.pop_front());
      void'(w_delay_q.pop_front());
    end
    if (r_unlock_req_i && !w_unlock_req_i) begin
      for (int w = 0; w < hm_pkg::WAYS; w++) begin
        if (r_unlock_i.way_ind[w]) begin
          lock_m[r_unlock_i.index][w] = 1'b0;
        end
      end
      void'(r_line_q.pop_front());
      void'(r_delay_q.pop_front());
    end
    if (cnt_down_i.valid) begin
      count_m[cnt_down_i.id]--;
    end
    accepted_now = valid_i && ready_o;
    if (accepted_now) begin
      sent_q.push_back(desc_i);
      accept_cnt++;
    end
  endtask

  // new input values a little after the edge
  task automatic drive_cycle();
    if (accepted_now) begin
      valid_i = 1'b0;
    end
    // random gaps between descriptors
    if (!valid_i && (accept_cnt < NUM_DESC) && ($urandom_range(3) != 0)) begin
      desc_i  = random_desc();
      valid_i = 1'b1;
    end
    hit_ready_i    = ($urandom_range(3) != 0);
    miss_ready_i   = ($urandom_range(3) != 0);
    // head of each unlock queue waits out its delay and then holds the request
    w_unlock_req_i = 1'b0;
    if (w_line_q.size() != 0) begin
      if (w_delay_q[0] != 0) begin
        w_delay_q[0] = w_delay_q[0] - 1;
      end else begin
        w_unlock_req_i = 1'b1;
        w_unlock_i     = w_line_q[0];
      end
    end
    r_unlock_req_i = 1'b0;
    if (r_line_q.size() != 0) begin
      if (r_delay_q[0] != 0) begin
        r_delay_q[0] = r_delay_q[0] - 1;
      end else begin
        r_unlock_req_i = 1'b1;
        r_unlock_i     = r_line_q[0];
      end
    end
    // count-down is a single pulse
    cnt_down_i = '0;
    if (cnt_id_q.size() != 0) begin
      if (cnt_delay_q[0] != 0) begin
        cnt_delay_q[0] = cnt_delay_q[0] - 1;
      end else begin
        cnt_down_i.id    = cnt_id_q.pop_front();
        cnt_down_i.valid = 1'b1;
        void'(cnt_delay_q.pop_front());
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(74745));
    reset_i        = 1'b1;
    desc_i         = '0;
    valid_i        = 1'b0;
    hit_ready_i    = 1'b0;
    miss_ready_i   = 1'b0;
    w_unlock_i     = '0;
    w_unlock_req_i = 1'b0;
    r_unlock_i     = '0;
    r_unlock_req_i = 1'b0;
    cnt_down_i     = '0;
    cycle_cnt      = 0;
    accept_cnt     = 0;
    done_cnt       = 0;
    accepted_now   = 1'b0;
    held_valid     = 1'b0;
    held_desc      = '0;
    // five sets in use with three lines each in sets 0 and 1
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = {hm_pkg::tag_t'(17 + i * 29), hm_pkg::index_t'(i % 5),
                 {hm_pkg::OFFSET_W{1'b0}}};
    end
    for (int s = 0; s < hm_pkg::SETS; s++) begin
      rr_m[s] = 0;
      for (int w = 0; w < hm_pkg::WAYS; w++) begin
        tag_m[s][w]   = '0;
        valid_m[s][w] = 1'b0;
        dirty_m[s][w] = 1'b0;
        lock_m[s][w]  = 1'b0;
      end
    end
    for (int i = 0; i < hm_pkg::NUM_IDS; i++) begin
      count_m[i] = 0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // first descriptor waits through the clear
    desc_i  = random_desc();
    valid_i = 1'b1;
    repeat (hm_pkg::SETS) begin
      @(posedge clk_i);
      cycle_cnt++;
      assert (!ready_o && !hit_valid_o && !miss_valid_o && !w_unlock_gnt_o && !r_unlock_gnt_o)
        else report_problem("unit active during the tag store clear");
    end
    while (done_cnt < NUM_DESC) begin
      @(posedge clk_i);
      cycle_cnt++;
      assert (cycle_cnt <= MAX_CYCLES) else report_problem("timeout: descriptors stopped flowing");
      // the clear walk takes exactly SETS cycles
      if (cycle_cnt == hm_pkg::SETS + 1) begin
        assert (ready_o) else report_problem("ready still low after the tag store clear");
      end
      observe_cycle();
      #2;
      drive_cycle();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* bench/hm_assert.sv */
`timescale 1ns/1ps

module hm_assert (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          ready_o,
  input  logic          hit_valid_o,
  input  logic          miss_valid_o,
  input  hm_pkg::desc_t desc_o,
  input  logic          w_unlock_gnt_o,
  input  logic          r_unlock_gnt_o
);

  // cycles since reset release, stops counting after the clear walk
  int unsigned since_reset_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      since_reset_q <= 0;
    end else if (since_reset_q < hm_pkg::SETS) begin
      since_reset_q <= since_reset_q + 1;
    end
  end

  // one output path at a time
  a_one_path: assert property (@(posedge clk_i) disable iff (reset_i)
    !(hit_valid_o && miss_valid_o))
    else $error("hit and miss valid are high together");

  // a valid output names exactly one way
  a_way_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(desc_o.way_ind))
    else $error("output way indicator is not one-hot");

  // no input while the tag store is being cleared
  a_init_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    (since_reset_q < hm_pkg::SETS) |-> !ready_o)
    else $error("ready raised during the tag store clear");

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    !(w_unlock_gnt_o && r_unlock_gnt_o))
    else $error("both unlock grants are high");

endmodule

bind hm_unit hm_assert u_hm_assert (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .ready_o        (ready_o),
  .hit_valid_o    (hit_valid_o),
  .miss_valid_o   (miss_valid_o),
  .desc_o         (desc_o),
  .w_unlock_gnt_o (w_unlock_gnt_o),
  .r_unlock_gnt_o (r_unlock_gnt_o)
);

/* verilog/hm_unit.sv */
`timescale 1ns/1ps

module hm_unit (
  input  logic          clk_i,
  input  logic          reset_i,
  input  hm_pkg::desc_t desc_i,
  input  logic          valid_i,
  output logic          ready_o,
  output hm_pkg::desc_t desc_o,
  output logic          hit_valid_o,
  input  logic          hit_ready_i,
  output logic          miss_valid_o,
  input  logic          miss_ready_i,
  input  hm_pkg::lock_t w_unlock_i,
  input  logic          w_unlock_req_i,
  output logic          w_unlock_gnt_o,
  input  hm_pkg::lock_t r_unlock_i,
  input  logic          r_unlock_req_i,
  output logic          r_unlock_gnt_o,
  input  hm_pkg::cnt_t  cnt_down_i
);

  // tag store handshake
  hm_pkg::store_req_t store_req;
  logic               store_req_valid;
  logic               store_req_ready;
  hm_pkg::store_res_t store_res;
  logic               store_res_valid;
  logic               store_res_ready;

  // lock table and miss counters
  hm_pkg::lock_t      lock;
  logic               lock_req;
  logic               locked;
  hm_pkg::cnt_t       cnt_up;
  logic               to_miss;
  logic               cnt_stall;

  // descriptor held in the unit
  logic               busy_q;
  hm_pkg::desc_t      desc_q;
  logic               send;
  logic               out_fire;

  //////////////////////////////////////////////////
  // output descriptor and routing
  //////////////////////////////////////////////////
  always_comb begin
    desc_o           = desc_q;
    // lookup fields come straight from the held response
    desc_o.way_ind   = store_res.way_ind;
    desc_o.refill    = ~store_res.hit;
    desc_o.evict     = store_res.evict;
    desc_o.evict_tag = store_res.evict_tag;
  end

  // hold back while the line is in use or the id counter is full
  assign send         = busy_q & store_res_valid & ~locked & ~cnt_stall;
  assign hit_valid_o  = send & store_res.hit & ~to_miss;
  assign miss_valid_o = send & (~store_res.hit | to_miss);
  assign out_fire     = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

  // releases the response on the transfer
  assign store_res_ready = out_fire;

  //////////////////////////////////////////////////
  // input side, lookup request
  //////////////////////////////////////////////////
  // next descriptor can enter on the cycle the current one leaves
  assign ready_o         = (~busy_q | out_fire) & store_req_ready;
  assign store_req_valid = valid_i & (~busy_q | out_fire);

  always_comb begin
    store_req.mode  = store_req_valid ? hm_pkg::TAG_LOOKUP : hm_pkg::TAG_IDLE;
    store_req.index = desc_i.addr[hm_pkg::OFFSET_W +: hm_pkg::INDEX_W];
    store_req.tag   = desc_i.addr[hm_pkg::ADDR_W-1 -: hm_pkg::TAG_W];
    store_req.dirty = desc_i.rw;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      busy_q <= 1'b1;
    end else if (out_fire) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      desc_q <= desc_i;
    end
  end

  // lock on every transfer, count up only on the miss path
  assign lock.index   = desc_q.addr[hm_pkg::OFFSET_W +: hm_pkg::INDEX_W];
  assign lock.way_ind = desc_o.way_ind;
  assign lock_req     = out_fire;
  assign cnt_up.id    = desc_q.id;
  assign cnt_up.valid = miss_valid_o & miss_ready_i;

  hm_tag_store u_tag_store (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (store_req),
    .req_valid_i (store_req_valid),
    .req_ready_o (store_req_ready),
    .res_o       (store_res),
    .res_valid_o (store_res_valid),
    .res_ready_i (store_res_ready)
  );

  hm_miss_counters u_miss_counters (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .id_i       (desc_q.id),
    .cnt_up_i   (cnt_up),
    .cnt_down_i (cnt_down_i),
    .to_miss_o  (to_miss),
    .stall_o    (cnt_stall)
  );

  hm_lock_table u_lock_table (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lock_i         (lock),
    .lock_req_i     (lock_req),
    .locked_o       (locked),
    .w_unlock_i     (w_unlock_i),
    .w_unlock_req_i (w_unlock_req_i),
    .w_unlock_gnt_o (w_unlock_gnt_o),
    .r_unlock_i     (r_unlock_i),
    .r_unlock_req_i (r_unlock_req_i),
    .r_unlock_gnt_o (r_unlock_gnt_o)
  );

endmodule

/* verilog/hm_lock_table.sv */
`timescale 1ns/1ps

module hm_lock_table (
  input  logic          clk_i,
  input  logic          reset_i,
  input  hm_pkg::lock_t lock_i,
  input  logic          lock_req_i,
  output logic          locked_o,
  input  hm_pkg::lock_t w_unlock_i,
  input  logic          w_unlock_req_i,
  output logic          w_unlock_gnt_o,
  input  hm_pkg::lock_t r_unlock_i,
  input  logic          r_unlock_req_i,
  output logic          r_unlock_gnt_o
);

  // one bit per set and way
  hm_pkg::way_ind_t lock_q [hm_pkg::SETS];
  hm_pkg::lock_t    unlock;
  logic             unlock_valid;

  //////////////////////////////////////////////////
  // unlock arbitration, write first
  //////////////////////////////////////////////////
  assign w_unlock_gnt_o = w_unlock_req_i;
  assign r_unlock_gnt_o = r_unlock_req_i & ~w_unlock_req_i;
  assign unlock_valid   = w_unlock_req_i | r_unlock_req_i;

  // granted line
  always_comb begin
    if (w_unlock_req_i) begin
      unlock = w_unlock_i;
    end else begin
      unlock = r_unlock_i;
    end
  end

  // query of the line the unit wants to send
  assign locked_o = |(lock_q[lock_i.index] & lock_i.way_ind);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < hm_pkg::SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < hm_pkg::SETS; s++) begin
        // clear first, then set
        if (lock_req_i && (lock_i.index == hm_pkg::index_t'(s))) begin
          lock_q[s] <= (unlock_valid && (unlock.index == hm_pkg::index_t'(s))) ?
                       ((lock_q[s] & ~unlock.way_ind) | lock_i.way_ind) :
                       (lock_q[s] | lock_i.way_ind);
        end else if (unlock_valid && (unlock.index == hm_pkg::index_t'(s))) begin
          lock_q[s] <= lock_q[s] & ~unlock.way_ind;
        end
      end
    end
  end

endmodule

/* verilog/hm_miss_counters.sv */
`timescale 1ns/1ps

module hm_miss_counters (
  input  logic         clk_i,
  input  logic         reset_i,
  input  hm_pkg::id_t  id_i,
  input  hm_pkg::cnt_t cnt_up_i,
  input  hm_pkg::cnt_t cnt_down_i,
  output logic         to_miss_o,
  output logic         stall_o
);

  // outstanding misses per id
  logic [hm_pkg::CNT_W-1:0]   cnt_q [hm_pkg::NUM_IDS];
  logic [hm_pkg::NUM_IDS-1:0] up;
  logic [hm_pkg::NUM_IDS-1:0] down;

  // decode the count events to one bit per id
  always_comb begin
    for (int i = 0; i < hm_pkg::NUM_IDS; i++) begin
      up[i]   = cnt_up_i.valid && (cnt_up_i.id == hm_pkg::id_t'(i));
      down[i] = cnt_down_i.valid && (cnt_down_i.id == hm_pkg::id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < hm_pkg::NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < hm_pkg::NUM_IDS; i++) begin
        // up and down together cancel out
        if (up[i] && !down[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down[i] && !up[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // any miss in flight, hits of this id must follow it
  assign to_miss_o = |cnt_q[id_i];
  // counter saturated, no further misses can be counted
  assign stall_o   = &cnt_q[id_i];

endmodule

/* verilog/hm_tag_store.sv */
`timescale 1ns/1ps

module hm_tag_store (
  input  logic               clk_i,
  input  logic               reset_i,
  input  hm_pkg::store_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output hm_pkg::store_res_t res_o,
  output logic               res_valid_o,
  input  logic               res_ready_i
);

  // storage, no reset, cleared by the init walk
  hm_pkg::tag_t       tag_q   [hm_pkg::SETS][hm_pkg::WAYS];
  hm_pkg::way_ind_t   valid_q [hm_pkg::SETS];
  hm_pkg::way_ind_t   dirty_q [hm_pkg::SETS];
  // round-robin victim per set, one-hot
  hm_pkg::way_ind_t   rr_q    [hm_pkg::SETS];

  logic               init_busy_q;
  hm_pkg::index_t     init_idx_q;
  hm_pkg::tag_mode_e  op;

  hm_pkg::way_ind_t   hit_way;
  hm_pkg::way_ind_t   free_way;
  hm_pkg::way_ind_t   victim;
  logic               hit;
  logic               victim_valid;
  logic               victim_dirty;
  hm_pkg::tag_t       victim_tag;
  hm_pkg::store_res_t res_q;
  logic               res_valid_q;

  // no requests while the clear walk runs
  assign req_ready_o = ~init_busy_q;
  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

  // effective operation this cycle
  always_comb begin
    if (init_busy_q) begin
      op = hm_pkg::TAG_INIT;
    end else if (req_valid_i) begin
      op = req_i.mode;
    end else begin
      op = hm_pkg::TAG_IDLE;
    end
  end

  //////////////////////////////////////////////////
  // lookup and victim selection
  //////////////////////////////////////////////////
  always_comb begin
    hit_way    = '0;
    free_way   = '0;
    victim_tag = '0;
    for (int w = 0; w < hm_pkg::WAYS; w++) begin
      hit_way[w] = valid_q[req_i.index][w] && (tag_q[req_i.index][w] == req_i.tag);
    end
    // scan downwards so the lowest invalid way wins
    for (int w = hm_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_q[req_i.index][w]) begin
        free_way = hm_pkg::way_ind_t'(1) << w;
      end
    end
    hit = |hit_way;
    if (hit) begin
      victim = hit_way;
    end else if (|free_way) begin
      victim = free_way;
    end else begin
      victim = rr_q[req_i.index];
    end
    victim_valid = |(victim & valid_q[req_i.index]);
    victim_dirty = |(victim & dirty_q[req_i.index]);
    for (int w = 0; w < hm_pkg::WAYS; w++) begin
      if (victim[w]) begin
        victim_tag = tag_q[req_i.index][w];
      end
    end
  end

  // array updates, tags written in the request cycle
  always_ff @(posedge clk_i) begin
    case (op)
      hm_pkg::TAG_INIT: begin
        valid_q[init_idx_q] <= '0;
        dirty_q[init_idx_q] <= '0;
        rr_q[init_idx_q]    <= hm_pkg::way_ind_t'(1);
      end
      hm_pkg::TAG_LOOKUP: begin
        for (int w = 0; w < hm_pkg::WAYS; w++) begin
          if (victim[w]) begin
            tag_q[req_i.index][w] <= req_i.tag;
          end
        end
        valid_q[req_i.index] <= valid_q[req_i.index] | victim;
        // a hit keeps the old dirty bit, a refill starts from rw
        if (hit) begin
          dirty_q[req_i.index] <= dirty_q[req_i.index] |
                                  (victim & {hm_pkg::WAYS{req_i.dirty}});
        end else begin
          dirty_q[req_i.index] <= (dirty_q[req_i.index] & ~victim) |
                                  (victim & {hm_pkg::WAYS{req_i.dirty}});
        end
        // rotate only when a valid line got replaced
        if (!hit && victim_valid) begin
          rr_q[req_i.index] <= {rr_q[req_i.index][hm_pkg::WAYS-2:0],
                                rr_q[req_i.index][hm_pkg::WAYS-1]};
        end
      end
      default: ;
    endcase
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (op == hm_pkg::TAG_LOOKUP) begin
      res_q.way_ind   <= victim;
      res_q.hit       <= hit;
      res_q.evict     <= ~hit & victim_valid & victim_dirty;
      res_q.evict_tag <= (~hit & victim_valid & victim_dirty) ? victim_tag : '0;
    end
  end

  //////////////////////////////////////////////////
  // init walk and response valid
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      init_busy_q <= 1'b1;
      init_idx_q  <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (op == hm_pkg::TAG_INIT) begin
        init_idx_q <= init_idx_q + 1'b1;
        // last set cleared
        if (init_idx_q == hm_pkg::index_t'(hm_pkg::SETS - 1)) begin
          init_busy_q <= 1'b0;
        end
      end
      // new lookup wins over the release of the old response
      if (op == hm_pkg::TAG_LOOKUP) begin
        res_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

endmodule

/* verilog/hm_pkg.sv */
package hm_pkg;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  // address is tag | index | offset
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned INDEX_W  = 4;
  localparam int unsigned SETS     = 16;
  localparam int unsigned TAG_W    = 8;
  localparam int unsigned WAYS     = 2;

  // transaction ids and per-id miss counting
  localparam int unsigned ID_W     = 2;
  localparam int unsigned NUM_IDS  = 4;
  // a counter at its max value stalls the unit
  localparam int unsigned CNT_W    = 3;

  //////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////

  // one-hot way select
  typedef logic [WAYS-1:0]    way_ind_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [ID_W-1:0]    id_t;

  // tag store operation
  typedef enum logic [1:0] {
    TAG_IDLE   = 2'd0,
    TAG_LOOKUP = 2'd1,
    TAG_INIT   = 2'd2
  } tag_mode_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // descriptor; addr, id and rw come in, the rest is filled by the lookup
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    id_t               id;
    // 1 = write
    logic              rw;
    way_ind_t          way_ind;
    logic              refill;
    logic              evict;
    tag_t              evict_tag;
  } desc_t;

  // names one line
  typedef struct packed {
    index_t   index;
    way_ind_t way_ind;
  } lock_t;

  // one count event for an id
  typedef struct packed {
    id_t  id;
    logic valid;
  } cnt_t;

  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } store_req_t;

  typedef struct packed {
    way_ind_t way_ind;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } store_res_t;

endpackage
